// File: run.sh
#!/usr/bin/env bash
# Build and run the add/sub unit regression with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_add_sub_unit \
    -f tb.f \
    -o sim_tb_add_sub_unit

# a failing assertion may end the run early, the search below decides
out=$(./obj_dir/sim_tb_add_sub_unit 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

// File: src/add_sub_unit.sv
`default_nettype none

module add_sub_unit #(
    parameter int RS_DEPTH = 4
) (
    input  wire                        clk,
    input  wire                        rst,

    input  wire                        dispatch_valid,
    input  tomasulo_pkg::roben_t       dispatch_roben,
    input  wire                        dispatch_sub,
    input  wire                        dispatch_op1_ready,
    input  tomasulo_pkg::word_t        dispatch_op1_value,
    input  tomasulo_pkg::roben_t       dispatch_op1_tag,
    input  wire                        dispatch_op2_ready,
    input  tomasulo_pkg::word_t        dispatch_op2_value,
    input  tomasulo_pkg::roben_t       dispatch_op2_tag,
    output logic                       full,

    input  wire                        cdb_valid,
    input  tomasulo_pkg::roben_t       cdb_roben,
    input  tomasulo_pkg::word_t        cdb_value,

    output logic                       result_valid,
    output tomasulo_pkg::word_t        result_value,
    output tomasulo_pkg::roben_t       result_roben,
    output logic                       result_overflow
);

    // station to adder, combinational from the slot registers
    logic                  issue_valid;
    tomasulo_pkg::word_t   issue_op1;
    tomasulo_pkg::word_t   issue_op2;
    logic                  issue_sub;
    tomasulo_pkg::roben_t  issue_roben;

    reservation_station #(
        .RS_DEPTH (RS_DEPTH)
    ) u_rs (
        .clk                (clk),
        .rst                (rst),
        .dispatch_valid     (dispatch_valid),
        .dispatch_roben     (dispatch_roben),
        .dispatch_sub       (dispatch_sub),
        .dispatch_op1_ready (dispatch_op1_ready),
        .dispatch_op1_value (dispatch_op1_value),
        .dispatch_op1_tag   (dispatch_op1_tag),
        .dispatch_op2_ready (dispatch_op2_ready),
        .dispatch_op2_value (dispatch_op2_value),
        .dispatch_op2_tag   (dispatch_op2_tag),
        .full               (full),
        .cdb_valid          (cdb_valid),
        .cdb_roben          (cdb_roben),
        .cdb_value          (cdb_value),
        .issue_valid        (issue_valid),
        .issue_op1          (issue_op1),
        .issue_op2          (issue_op2),
        .issue_sub          (issue_sub),
        .issue_roben        (issue_roben)
    );

    cla_adder u_adder (
        .clk             (clk),
        .rst             (rst),
        .issue_valid     (issue_valid),
        .issue_op1       (issue_op1),
        .issue_op2       (issue_op2),
        .issue_sub       (issue_sub),
        .issue_roben     (issue_roben),
        .result_valid    (result_valid),
        .result_value    (result_value),
        .result_roben    (result_roben),
        .result_overflow (result_overflow)
    );

endmodule

`default_nettype wire

// File: src/cla_4_bit.sv
`default_nettype none

module cla_4_bit (
    input  wire  [3:0] a,
    input  wire  [3:0] b,
    input  wire        cin,
    input  wire        sub,
    output logic [3:0] sum,
    output logic       cout,
    output logic       c_msb
);

    logic [3:0] b_eff;
    logic [3:0] g;
    logic [3:0] p;
    logic [4:1] c;

    // one's complement of b, the +1 comes in through cin of slice 0
    assign b_eff = b ^ {4{sub}};

    assign g = a & b_eff;
    assign p = a ^ b_eff;

    // every carry expanded directly in terms of g, p and cin
    assign c[1] = g[0] | (p[0] & cin);
    assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
    assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                | (p[2] & p[1] & p[0] & cin);
    assign c[4] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                | (p[3] & p[2] & p[1] & g[0])
                | (p[3] & p[2] & p[1] & p[0] & cin);

    assign sum = p ^ {c[3], c[2], c[1], cin};

    assign cout = c[4];

    // carry into the top bit, needed for signed overflow in the last slice
    assign c_msb = c[3];

endmodule

`default_nettype wire

// File: src/cla_adder.sv
`default_nettype none

module cla_adder (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        issue_valid,
    input  tomasulo_pkg::word_t        issue_op1,
    input  tomasulo_pkg::word_t        issue_op2,
    input  wire                        issue_sub,
    input  tomasulo_pkg::roben_t       issue_roben,
    output logic                       result_valid,
    output tomasulo_pkg::word_t        result_value,
    output tomasulo_pkg::roben_t       result_roben,
    output logic                       result_overflow
);

    localparam int NUM_SLICES = tomasulo_pkg::XLEN / 4;

    // carry[0] is the subtract +1, carry[k] leaves slice k-1
    logic [NUM_SLICES:0]   carry;
    logic [NUM_SLICES-1:0] slice_c_msb;
    tomasulo_pkg::word_t   sum;
    logic                  overflow;

    assign carry[0] = issue_sub;

    genvar k;
    generate
        for (k = 0; k < NUM_SLICES; k++) begin : g_slice
            cla_4_bit u_slice (
                .a     (issue_op1[4*k +: 4]),
                .b     (issue_op2[4*k +: 4]),
                .cin   (carry[k]),
                .sub   (issue_sub),
                .sum   (sum[4*k +: 4]),
                .cout  (carry[k+1]),
                .c_msb (slice_c_msb[k])
            );
        end
    endgenerate

    // signed overflow when carry into the sign bit differs from carry out
    assign overflow = slice_c_msb[NUM_SLICES-1] ^ carry[NUM_SLICES];

    // output register driving this unit's CDB broadcast
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            result_value    <= sum;
            result_roben    <= issue_roben;
            result_overflow <= overflow;
        end
    end

endmodule

`default_nettype wire

// File: src/reservation_station.sv
`default_nettype none

module reservation_station #(
    parameter int RS_DEPTH = 4
) (
    input  wire                        clk,
    input  wire                        rst,

    // dispatch
    input  wire                        dispatch_valid,
    input  tomasulo_pkg::roben_t       dispatch_roben,
    input  wire                        dispatch_sub,
    input  wire                        dispatch_op1_ready,
    input  tomasulo_pkg::word_t        dispatch_op1_value,
    input  tomasulo_pkg::roben_t       dispatch_op1_tag,
    input  wire                        dispatch_op2_ready,
    input  tomasulo_pkg::word_t        dispatch_op2_value,
    input  tomasulo_pkg::roben_t       dispatch_op2_tag,
    output logic                       full,

    // common data bus snoop
    input  wire                        cdb_valid,
    input  tomasulo_pkg::roben_t       cdb_roben,
    input  tomasulo_pkg::word_t        cdb_value,

    // issue to the adder
    output logic                       issue_valid,
    output tomasulo_pkg::word_t        issue_op1,
    output tomasulo_pkg::word_t        issue_op2,
    output logic                       issue_sub,
    output tomasulo_pkg::roben_t       issue_roben
);

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    // slot storage
    tomasulo_pkg::slot_state_t state_q     [RS_DEPTH];
    logic                      sub_q       [RS_DEPTH];
    tomasulo_pkg::roben_t      roben_q     [RS_DEPTH];
    logic [RS_DEPTH-1:0]       op1_ready_q;
    logic [RS_DEPTH-1:0]       op2_ready_q;
    tomasulo_pkg::word_t       op1_value_q [RS_DEPTH];
    tomasulo_pkg::word_t       op2_value_q [RS_DEPTH];
    tomasulo_pkg::roben_t      op1_tag_q   [RS_DEPTH];
    tomasulo_pkg::roben_t      op2_tag_q   [RS_DEPTH];

    // per slot CDB match on a still pending operand
    logic [RS_DEPTH-1:0]       op1_hit;
    logic [RS_DEPTH-1:0]       op2_hit;

    logic                      alloc_found;
    logic [IDX_W-1:0]          alloc_idx;
    logic                      alloc_en;
    logic                      issue_found;
    logic [IDX_W-1:0]          issue_idx;

    // dispatch operands after bypass from the current broadcast
    logic                      disp_op1_rdy;
    logic                      disp_op2_rdy;
    tomasulo_pkg::word_t       disp_op1_val;
    tomasulo_pkg::word_t       disp_op2_val;

    // lowest free slot, scanning down so the smallest index wins
    always_comb begin
        alloc_found = 1'b0;
        alloc_idx   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (state_q[i] == tomasulo_pkg::SLOT_FREE) begin
                alloc_found = 1'b1;
                alloc_idx   = IDX_W'(i);
            end
        end
    end

    assign full     = ~alloc_found;
    // strobe while full is dropped
    assign alloc_en = dispatch_valid & alloc_found;

    // lowest ready slot goes to the adder
    always_comb begin
        issue_found = 1'b0;
        issue_idx   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (state_q[i] == tomasulo_pkg::SLOT_READY) begin
                issue_found = 1'b1;
                issue_idx   = IDX_W'(i);
            end
        end
    end

    assign issue_valid = issue_found;
    assign issue_op1   = op1_value_q[issue_idx];
    assign issue_op2   = op2_value_q[issue_idx];
    assign issue_sub   = sub_q[issue_idx];
    assign issue_roben = roben_q[issue_idx];

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            op1_hit[i] = cdb_valid && (state_q[i] == tomasulo_pkg::SLOT_WAIT)
                      && !op1_ready_q[i] && (op1_tag_q[i] == cdb_roben);
            op2_hit[i] = cdb_valid && (state_q[i] == tomasulo_pkg::SLOT_WAIT)
                      && !op2_ready_q[i] && (op2_tag_q[i] == cdb_roben);
        end
    end

    // a tag broadcast in the dispatch cycle is taken at allocation
    assign disp_op1_rdy = dispatch_op1_ready
                        | (cdb_valid && (dispatch_op1_tag == cdb_roben));
    assign disp_op2_rdy = dispatch_op2_ready
                        | (cdb_valid && (dispatch_op2_tag == cdb_roben));
    assign disp_op1_val = dispatch_op1_ready ? dispatch_op1_value : cdb_value;
    assign disp_op2_val = dispatch_op2_ready ? dispatch_op2_value : cdb_value;

    // slot state and operand ready bits
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                state_q[i]     <= tomasulo_pkg::SLOT_FREE;
                op1_ready_q[i] <= 1'b0;
                op2_ready_q[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (alloc_en && (alloc_idx == IDX_W'(i))) begin
                    op1_ready_q[i] <= disp_op1_rdy;
                    op2_ready_q[i] <= disp_op2_rdy;
                    if (disp_op1_rdy && disp_op2_rdy) begin
                        state_q[i] <= tomasulo_pkg::SLOT_READY;
                    end else begin
                        state_q[i] <= tomasulo_pkg::SLOT_WAIT;
                    end
                end else if (issue_found && (issue_idx == IDX_W'(i))) begin
                    state_q[i]     <= tomasulo_pkg::SLOT_FREE;
                    op1_ready_q[i] <= 1'b0;
                    op2_ready_q[i] <= 1'b0;
                end else if (state_q[i] == tomasulo_pkg::SLOT_WAIT) begin
                    op1_ready_q[i] <= op1_ready_q[i] | op1_hit[i];
                    op2_ready_q[i] <= op2_ready_q[i] | op2_hit[i];
                    if ((op1_ready_q[i] | op1_hit[i]) && (op2_ready_q[i] | op2_hit[i])) begin
                        state_q[i] <= tomasulo_pkg::SLOT_READY;
                    end
                end
            end
        end
    end

    // slot payload, written at allocation or when a wakeup lands
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (alloc_en && (alloc_idx == IDX_W'(i))) begin
                sub_q[i]       <= dispatch_sub;
                roben_q[i]     <= dispatch_roben;
                op1_value_q[i] <= disp_op1_val;
                op2_value_q[i] <= disp_op2_val;
                op1_tag_q[i]   <= dispatch_op1_tag;
                op2_tag_q[i]   <= dispatch_op2_tag;
            end else begin
                if (op1_hit[i]) begin
                    op1_value_q[i] <= cdb_value;
                end
                if (op2_hit[i]) begin
                    op2_value_q[i] <= cdb_value;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/tomasulo_pkg.sv
`default_nettype none

package tomasulo_pkg;

    // datapath width, the adder is built from 4-bit slices of this
    localparam int XLEN = 32;

    // reorder buffer index width
    localparam int ROBEN_WIDTH = 5;

    // operand or result value
    typedef logic [XLEN-1:0] word_t;

    // reorder buffer entry number, also the tag a pending operand waits on
    typedef logic [ROBEN_WIDTH-1:0] roben_t;

    // reservation station slot occupancy
    // SLOT_WAIT means at least one operand still pending on the CDB
    typedef enum logic [1:0] {
        SLOT_FREE  = 2'd0,
        SLOT_WAIT  = 2'd1,
        SLOT_READY = 2'd2
    } slot_state_t;

endpackage

`default_nettype wire

// File: tb.f
src/tomasulo_pkg.sv
src/cla_4_bit.sv
src/cla_adder.sv
src/reservation_station.sv
src/add_sub_unit.sv
testbench/add_sub_unit_chk.sv
testbench/tb_add_sub_unit.sv

// File: testbench/add_sub_unit_chk.sv
`default_nettype none

module add_sub_unit_chk (
    input wire                  clk,
    input wire                  rst,
    input wire                  dispatch_valid,
    input wire                  dispatch_op1_ready,
    input wire                  dispatch_op2_ready,
    input wire                  full,
    input wire                  cdb_valid,
    input wire                  issue_valid,
    input wire                  result_valid,
    input tomasulo_pkg::roben_t result_roben
);

    // output stage is cleared by reset
    a_reset_clears_result: assert property (@(posedge clk) rst |=> !result_valid)
        else $error("result_valid high in the cycle after reset");

    a_no_dispatch_when_full: assert property (@(posedge clk) disable iff (rst)
        full |-> !dispatch_valid)
        else $error("dispatch strobe while the station is full");

    // outstanding ROBENs are unique, so back to back results never share one
    a_no_repeat_roben: assert property (@(posedge clk) disable iff (rst)
        (result_valid && $past(result_valid)) |-> (result_roben != $past(result_roben)))
        else $error("same ROBEN broadcast on two consecutive cycles");

    // nothing ready and no wakeup this edge, so the new entry issues next
    a_ready_latency: assert property (@(posedge clk) disable iff (rst)
        (dispatch_valid && !full && dispatch_op1_ready && dispatch_op2_ready
         && !issue_valid && !cdb_valid) |-> ##2 result_valid)
        else $error("ready dispatch into an idle station gave no result two cycles later");

endmodule

bind add_sub_unit add_sub_unit_chk u_chk (
    .clk                (clk),
    .rst                (rst),
    .dispatch_valid     (dispatch_valid),
    .dispatch_op1_ready (dispatch_op1_ready),
    .dispatch_op2_ready (dispatch_op2_ready),
    .full               (full),
    .cdb_valid          (cdb_valid),
    .issue_valid        (issue_valid),
    .result_valid       (result_valid),
    .result_roben       (result_roben)
);

`default_nettype wire

// File: testbench/tb_add_sub_unit.sv
`default_nettype none

module tb_add_sub_unit;

    localparam int RS_DEPTH      = 4;
    localparam int RANDOM_CYCLES = 300;
    // rough per test lengths in cycles
    localparam int LEN_READY     = 16 * 8;
    localparam int LEN_WAKEUP    = 60;
    localparam int LEN_BYPASS    = 20;
    localparam int LEN_FILL      = 60;
    localparam int LEN_RANDOM    = RANDOM_CYCLES + 100;
    localparam int CYCLE_LIMIT   = 10 + LEN_READY + LEN_WAKEUP + LEN_BYPASS + LEN_FILL
                                 + LEN_RANDOM + 200;
    localparam int WAIT_LIMIT    = 40;

    logic                 clk;
    logic                 rst;
    logic                 dispatch_valid;
    tomasulo_pkg::roben_t dispatch_roben;
    logic                 dispatch_sub;
    logic                 dispatch_op1_ready;
    tomasulo_pkg::word_t  dispatch_op1_value;
    tomasulo_pkg::roben_t dispatch_op1_tag;
    logic                 dispatch_op2_ready;
    tomasulo_pkg::word_t  dispatch_op2_value;
    tomasulo_pkg::roben_t dispatch_op2_tag;
    logic                 full;
    logic                 cdb_valid;
    tomasulo_pkg::roben_t cdb_roben;
    tomasulo_pkg::word_t  cdb_value;
    logic                 result_valid;
    tomasulo_pkg::word_t  result_value;
    tomasulo_pkg::roben_t result_roben;
    logic                 result_overflow;

    // scoreboard keyed by ROBEN
    logic                exp_valid [32];
    tomasulo_pkg::word_t exp_value [32];
    logic                exp_ovf   [32];
    tomasulo_pkg::word_t tag_val   [32];

    int seed = 17600;
    int errors;
    int checks;
    int returned;
    int outstanding;
    int cycle_count;
    int last_result_cycle;

    add_sub_unit #(
        .RS_DEPTH (RS_DEPTH)
    ) DUT (
        .clk                (clk),
        .rst                (rst),
        .dispatch_valid     (dispatch_valid),
        .dispatch_roben     (dispatch_roben),
        .dispatch_sub       (dispatch_sub),
        .dispatch_op1_ready (dispatch_op1_ready),
        .dispatch_op1_value (dispatch_op1_value),
        .dispatch_op1_tag   (dispatch_op1_tag),
        .dispatch_op2_ready (dispatch_op2_ready),
        .dispatch_op2_value (dispatch_op2_value),
        .dispatch_op2_tag   (dispatch_op2_tag),
        .full               (full),
        .cdb_valid          (cdb_valid),
        .cdb_roben          (cdb_roben),
        .cdb_value          (cdb_value),
        .result_valid       (result_valid),
        .result_value       (result_value),
        .result_roben       (result_roben),
        .result_overflow    (result_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, results still missing", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    // 33-bit signed result, overflow when it leaves the 32-bit signed range
    function automatic void model(input tomasulo_pkg::word_t a, input tomasulo_pkg::word_t b,
                                  input logic s, output tomasulo_pkg::word_t v,
                                  output logic ovf);
        longint wide;
        if (s) begin
            wide = longint'($signed(a)) - longint'($signed(b));
        end else begin
            wide = longint'($signed(a)) + longint'($signed(b));
        end
        v   = wide[31:0];
        ovf = wide[32] != wide[31];
    endfunction

    // result monitor, sampled away from the active edge
    always @(negedge clk) begin
        if (!rst && result_valid) begin
            checks++;
            assert (exp_valid[result_roben]) else begin
                $display("unexpected result for ROBEN %0d at time %0t", result_roben, $time);
                errors++;
            end
            if (exp_valid[result_roben]) begin
                assert (result_value == exp_value[result_roben]
                        && result_overflow == exp_ovf[result_roben]) else begin
                    $display("Mismatch at %0t: ROBEN %0d got %h ovf %b, expected %h ovf %b",
                             $time, result_roben, result_value, result_overflow,
                             exp_value[result_roben], exp_ovf[result_roben]);
                    errors++;
                end
                exp_valid[result_roben] = 1'b0;
                outstanding--;
            end
            returned++;
            last_result_cycle = cycle_count;
        end
    end

    task automatic expect_result(input int r, input tomasulo_pkg::word_t a,
                                 input tomasulo_pkg::word_t b, input logic s);
        tomasulo_pkg::word_t v;
        logic ovf;
        model(a, b, s, v, ovf);
        exp_valid[r] = 1'b1;
        exp_value[r] = v;
        exp_ovf[r]   = ovf;
        outstanding++;
    endtask

    // call right after a rising edge
    task automatic drive_dispatch(input int r, input logic s,
                                  input logic r1, input tomasulo_pkg::word_t v1, input int t1,
                                  input logic r2, input tomasulo_pkg::word_t v2, input int t2);
        dispatch_valid     <= 1'b1;
        dispatch_roben     <= tomasulo_pkg::roben_t'(r);
        dispatch_sub       <= s;
        dispatch_op1_ready <= r1;
        dispatch_op1_value <= v1;
        dispatch_op1_tag   <= tomasulo_pkg::roben_t'(t1);
        dispatch_op2_ready <= r2;
        dispatch_op2_value <= v2;
        dispatch_op2_tag   <= tomasulo_pkg::roben_t'(t2);
    endtask

    task automatic drive_cdb(input int t);
        cdb_valid <= 1'b1;
        cdb_roben <= tomasulo_pkg::roben_t'(t);
        cdb_value <= tag_val[t];
    endtask

    task automatic clear_inputs();
        dispatch_valid <= 1'b0;
        cdb_valid      <= 1'b0;
    endtask

    task automatic wait_results(input int target, input string what);
        int n;
        n = 0;
        while (returned < target && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (returned >= target) else begin
            $display("%s: result did not arrive within %0d cycles", what, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %s done, no errors", name);
        end else begin
            $display("test %s done, %0d errors", name, errors - err_before);
        end
    endtask

    task automatic run_ready_op(input int r, input tomasulo_pkg::word_t a,
                                input tomasulo_pkg::word_t b, input logic s);
        int disp_cycle;
        expect_result(r, a, b, s);
        @(posedge clk);
        drive_dispatch(r, s, 1'b1, a, 0, 1'b1, b, 0);
        @(posedge clk);
        clear_inputs();
        @(negedge clk);
        disp_cycle = cycle_count;
        wait_results(returned + 1, "ready op");
        checks++;
        // one edge issues into the adder, the next registers the result
        assert (last_result_cycle - disp_cycle == 1) else begin
            $display("Mismatch at %0t: ROBEN %0d latency %0d edges after capture",
                     $time, r, last_result_cycle - disp_cycle);
            errors++;
        end
    endtask

    task automatic test_ready();
        int e0;
        int x;
        int y;
        e0 = errors;
        run_ready_op(1, 32'h7fffffff, 32'h00000001, 1'b0);
        run_ready_op(2, 32'h80000000, 32'h00000001, 1'b1);
        run_ready_op(3, 32'h00000000, 32'h80000000, 1'b1);
        run_ready_op(4, 32'hffffffff, 32'h00000001, 1'b0);
        run_ready_op(5, 32'h00000005, 32'h00000007, 1'b1);
        run_ready_op(6, 32'h80000000, 32'h80000000, 1'b0);
        for (int i = 0; i < 10; i++) begin
            x = $random(seed);
            y = $random(seed);
            run_ready_op(7 + i, x, y, i[0]);
        end
        report_test("ready", e0);
    endtask

    task automatic test_wakeup();
        int e0;
        int r0;
        e0 = errors;
        r0 = returned;
        tag_val[20] = 32'h12345678;
        tag_val[21] = 32'h0000ffff;
        tag_val[25] = 32'hdeadbeef;
        expect_result(1, tag_val[20], 32'd100, 1'b0);
        expect_result(2, 32'd7, tag_val[21], 1'b1);
        @(posedge clk);
        drive_dispatch(1, 1'b0, 1'b0, 32'h0, 20, 1'b1, 32'd100, 0);
        @(posedge clk);
        drive_dispatch(2, 1'b1, 1'b1, 32'd7, 0, 1'b0, 32'h0, 21);
        @(posedge clk);
        clear_inputs();
        // unrelated tag must leave both slots waiting
        drive_cdb(25);
        @(posedge clk);
        clear_inputs();
        repeat (5) @(negedge clk);
        checks++;
        assert (returned == r0) else begin
            $display("result appeared before its operand tag was broadcast");
            errors++;
        end
        @(posedge clk);
        drive_cdb(20);
        @(posedge clk);
        clear_inputs();
        wait_results(r0 + 1, "wakeup tag 20");
        @(posedge clk);
        drive_cdb(21);
        @(posedge clk);
        clear_inputs();
        wait_results(r0 + 2, "wakeup tag 21");
        report_test("wakeup", e0);
    endtask

    task automatic test_bypass();
        int e0;
        e0 = errors;
        tag_val[22] = 32'h80000001;
        expect_result(3, 32'hffffffff, tag_val[22], 1'b0);
        @(posedge clk);
        drive_dispatch(3, 1'b0, 1'b1, 32'hffffffff, 0, 1'b0, 32'h0, 22);
        drive_cdb(22);
        @(posedge clk);
        clear_inputs();
        wait_results(returned + 1, "bypass");
        report_test("bypass", e0);
    endtask

    task automatic test_fill();
        int e0;
        int r0;
        int n;
        e0 = errors;
        r0 = returned;
        for (int i = 0; i < RS_DEPTH; i++) begin
            tag_val[24 + i] = 32'h01000000 * (i + 1);
            expect_result(8 + i, 32'd1000 + i, tag_val[24 + i], i[0]);
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            @(posedge clk);
            drive_dispatch(8 + i, i[0], 1'b1, 32'd1000 + i, 0, 1'b0, 32'h0, 24 + i);
        end
        @(posedge clk);
        clear_inputs();
        @(negedge clk);
        checks++;
        assert (full) else begin
            $display("Mismatch at %0t: full low with every slot waiting", $time);
            errors++;
        end
        @(posedge clk);
        drive_cdb(26);
        @(posedge clk);
        clear_inputs();
        n = 0;
        while (full && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (!full) else begin
            $display("full stayed high after a slot was released");
            errors++;
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (i != 2) begin
                @(posedge clk);
                drive_cdb(24 + i);
            end
        end
        @(posedge clk);
        clear_inputs();
        wait_results(r0 + RS_DEPTH, "fill and drain");
        checks++;
        assert (outstanding == 0) else begin
            $display("some ROBEN of the fill test never returned");
            errors++;
        end
        report_test("fill", e0);
    endtask

    task automatic test_random();
        int e0;
        int r0;
        int sent;
        int next_r;
        int x;
        int a;
        int b;
        int t1;
        int t2;
        logic r1;
        logic r2;
        logic send;
        e0 = errors;
        r0 = returned;
        sent = 0;
        next_r = 0;
        // pending operands wait on tags 16..31, instructions use ROBEN 0..15
        for (int t = 16; t < 32; t++) begin
            tag_val[t] = $random(seed);
        end
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            @(negedge clk);
            x  = $random(seed);
            a  = $random(seed);
            b  = $random(seed);
            r1 = x[0];
            r2 = x[1];
            t1 = 16 + int'(x[7:4]);
            t2 = 16 + int'(x[11:8]);
            // no allocation pending, so a free slot now is still free at capture
            send = x[2] && !full && !dispatch_valid;
            @(posedge clk);
            clear_inputs();
            if (x[14:12] < 3'd3) begin
                drive_cdb(16 + int'(x[19:16]));
            end
            if (send && !exp_valid[next_r]) begin
                expect_result(next_r, r1 ? a : tag_val[t1], r2 ? b : tag_val[t2], x[3]);
                drive_dispatch(next_r, x[3], r1, a, t1, r2, b, t2);
                sent++;
                next_r = (next_r + 1) % 16;
            end
        end
        for (int t = 16; t < 32; t++) begin
            @(posedge clk);
            clear_inputs();
            drive_cdb(t);
        end
        @(posedge clk);
        clear_inputs();
        wait_results(r0 + sent, "random drain");
        checks++;
        assert (returned - r0 == sent) else begin
            $display("Mismatch at %0t: %0d results for %0d dispatches",
                     $time, returned - r0, sent);
            errors++;
        end
        report_test("random", e0);
    endtask

    initial begin
        errors             = 0;
        checks             = 0;
        returned           = 0;
        outstanding        = 0;
        cycle_count        = 0;
        last_result_cycle  = 0;
        rst                = 1'b1;
        dispatch_valid     = 1'b0;
        dispatch_roben     = '0;
        dispatch_sub       = 1'b0;
        dispatch_op1_ready = 1'b0;
        dispatch_op1_value = '0;
        dispatch_op1_tag   = '0;
        dispatch_op2_ready = 1'b0;
        dispatch_op2_value = '0;
        dispatch_op2_tag   = '0;
        cdb_valid          = 1'b0;
        cdb_roben          = '0;
        cdb_value          = '0;
        for (int i = 0; i < 32; i++) begin
            exp_valid[i] = 1'b0;
            exp_value[i] = '0;
            exp_ovf[i]   = 1'b0;
            tag_val[i]   = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checks++;
        assert (!full && !result_valid) else begin
            $display("Mismatch at %0t: full or result_valid high after reset", $time);
            errors++;
        end
        test_ready();
        test_wakeup();
        test_bypass();
        test_fill();
        test_random();
        repeat (4) @(negedge clk);
        $display("checks %0d, errors %0d, results %0d", checks, errors, returned);
        if (errors == 0 && outstanding == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
